// File: rc5ParamPkg.sv
package rc5ParamPkg;

    // RC5-32/12/16 sizes
    localparam int WordWidth  = 32;
    localparam int NumRounds  = 12;
    localparam int KeyWords   = 4;
    localparam int TableWords = 2 * NumRounds + 2;
    // Three passes over the larger of table and key
    localparam int MixSteps   = 3 * TableWords;
    localparam int RotBits    = $clog2(WordWidth);

    typedef logic [WordWidth-1:0] rc5WordT;
    typedef rc5WordT [TableWords-1:0] keyTableT;

    // Magic constants from e and golden ratio
    localparam rc5WordT MagicP = 32'hB7E15163;
    localparam rc5WordT MagicQ = 32'h9E3779B9;

    // Data dependent rotations
    function automatic rc5WordT rotLeft(rc5WordT val, logic [RotBits-1:0] amt);
        return (val << amt) | (val >> (WordWidth - amt));
    endfunction

    function automatic rc5WordT rotRight(rc5WordT val, logic [RotBits-1:0] amt);
        return (val >> amt) | (val << (WordWidth - amt));
    endfunction

endpackage

// File: rc5PipePkg.sv
package rc5PipePkg;

    // Per-block opcode, travels with the data
    typedef enum logic {
        OpEncrypt,
        OpDecrypt
    } rc5OpT;

    ////////////////////////////////////////////////////////////
    // Key schedule FSM
    ////////////////////////////////////////////////////////////

    // Idle until first key, Mix while expanding, Done when table usable
    typedef enum logic [1:0] {
        KeyIdle,
        KeyMix,
        KeyDone
    } keyStateT;

endpackage

// File: rc5StageIf.sv
`timescale 1ns/1ps

// One block hop between two pipeline stages
interface rc5StageIf;
    import rc5ParamPkg::*;
    import rc5PipePkg::*;

    logic    valid;
    logic    ready;
    rc5OpT   op;
    // Word A is the upper half of the block
    rc5WordT wordA;
    rc5WordT wordB;

    // Producer side
    modport source (
        output valid, op, wordA, wordB,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid, op, wordA, wordB,
        output ready
    );

endinterface

// File: rc5KeyExpand.sv
`timescale 1ns/1ps

module rc5KeyExpand (
    input  logic                                                     clk,
    input  logic                                                     clr,
    input  logic                                                     i_keyValid,
    input  logic [rc5ParamPkg::KeyWords*rc5ParamPkg::WordWidth-1:0] i_key,
    input  logic                                                     i_pipeEmpty,
    output logic                                                     o_keyReady,
    output logic                                                     o_tableValid,
    output rc5ParamPkg::keyTableT                                    o_keyTable
);
    import rc5ParamPkg::*;
    import rc5PipePkg::*;

    localparam int StepBits = $clog2(MixSteps + 1);
    localparam int TIdxBits = $clog2(TableWords);
    localparam int KIdxBits = $clog2(KeyWords);

    keyStateT            state;
    logic [StepBits-1:0] stepCnt;
    logic [TIdxBits-1:0] tIdx;
    logic [KIdxBits-1:0] kIdx;
    rc5WordT             mixA;
    rc5WordT             mixB;
    rc5WordT             keyWord [KeyWords];
    keyTableT            subKeys;
    rc5WordT             nextA;
    rc5WordT             nextB;
    rc5WordT             rotSum;
    logic                keyTake;
    logic                mixStep;

    // New key only between bursts, with nothing in flight
    assign o_keyReady   = ((state == KeyIdle) || (state == KeyDone)) && i_pipeEmpty;
    assign keyTake      = i_keyValid && o_keyReady;
    // Last count is a settle cycle, no mixing
    assign mixStep      = (state == KeyMix) && (stepCnt != StepBits'(MixSteps));
    assign o_tableValid = (state == KeyDone);
    assign o_keyTable   = subKeys;

    ////////////////////////////////////////////////////////////
    // One mixing step
    ////////////////////////////////////////////////////////////
    always_comb begin
        // A = S[i] = (S[i] + A + B) <<< 3
        nextA  = rotLeft(subKeys[tIdx] + mixA + mixB, RotBits'(3));
        // B = L[j] = (L[j] + A + B) <<< (A + B)
        rotSum = nextA + mixB;
        nextB  = rotLeft(keyWord[kIdx] + rotSum, rotSum[RotBits-1:0]);
    end

    // Step counter, indices and state
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            state   <= KeyIdle;
            stepCnt <= '0;
            tIdx    <= '0;
            kIdx    <= '0;
        end else if (keyTake) begin
            state   <= KeyMix;
            stepCnt <= '0;
            tIdx    <= '0;
            kIdx    <= '0;
        end else if (mixStep) begin
            stepCnt <= stepCnt + 1'b1;
            // Table index wraps at 26, key index at 4
            tIdx    <= (tIdx == TIdxBits'(TableWords - 1)) ? '0 : tIdx + 1'b1;
            kIdx    <= (kIdx == KIdxBits'(KeyWords - 1)) ? '0 : kIdx + 1'b1;
        end else if (state == KeyMix) begin
            state <= KeyDone;
        end
    end

    // Table and key words
    always_ff @(posedge clk) begin
        if (keyTake) begin
            // S[n] = P + n*Q
            for (int n = 0; n < TableWords; n++) begin
                subKeys[n] <= MagicP + WordWidth'(n) * MagicQ;
            end
            // Little-endian key words
            for (int k = 0; k < KeyWords; k++) begin
                keyWord[k] <= i_key[k*WordWidth +: WordWidth];
            end
            mixA <= '0;
            mixB <= '0;
        end else if (mixStep) begin
            subKeys[tIdx] <= nextA;
            keyWord[kIdx] <= nextB;
            mixA          <= nextA;
            mixB          <= nextB;
        end
    end

endmodule

// File: rc5WhitenStage.sv
`timescale 1ns/1ps

module rc5WhitenStage #(
    parameter bit AtOutput = 1'b0
) (
    input  logic                  clk,
    input  logic                  clr,
    input  rc5ParamPkg::keyTableT i_keyTable,
    rc5StageIf.sink               upstream,
    rc5StageIf.source             downstream
);
    import rc5ParamPkg::*;
    import rc5PipePkg::*;

    logic    slotValid;
    rc5OpT   slotOp;
    rc5WordT slotA;
    rc5WordT slotB;
    logic    applyKey;
    rc5WordT whiteA;
    rc5WordT whiteB;

    // Slot accepts when empty or draining this cycle
    assign upstream.ready = !slotValid || downstream.ready;

    always_comb begin
        // Entry whitens encrypt, exit unwhitens decrypt
        applyKey = AtOutput ? (upstream.op == OpDecrypt) : (upstream.op == OpEncrypt);
        whiteA   = upstream.wordA;
        whiteB   = upstream.wordB;
        if (applyKey) begin
            if (AtOutput) begin
                whiteA = upstream.wordA - i_keyTable[0];
                whiteB = upstream.wordB - i_keyTable[1];
            end else begin
                whiteA = upstream.wordA + i_keyTable[0];
                whiteB = upstream.wordB + i_keyTable[1];
            end
        end
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            slotValid <= 1'b0;
        end else if (upstream.ready) begin
            slotValid <= upstream.valid;
        end
    end

    // Block payload
    always_ff @(posedge clk) begin
        if (upstream.valid && upstream.ready) begin
            slotOp <= upstream.op;
            slotA  <= whiteA;
            slotB  <= whiteB;
        end
    end

    assign downstream.valid = slotValid;
    assign downstream.op    = slotOp;
    assign downstream.wordA = slotA;
    assign downstream.wordB = slotB;

endmodule

// File: rc5RoundStage.sv
`timescale 1ns/1ps

module rc5RoundStage #(
    parameter int RoundIdx = 1
) (
    input  logic                  clk,
    input  logic                  clr,
    input  rc5ParamPkg::keyTableT i_keyTable,
    rc5StageIf.sink               upstream,
    rc5StageIf.source             downstream
);
    import rc5ParamPkg::*;
    import rc5PipePkg::*;

    // Decrypt walks the rounds backwards
    localparam int EncRound = RoundIdx;
    localparam int DecRound = NumRounds + 1 - RoundIdx;

    logic    slotValid;
    rc5OpT   slotOp;
    rc5WordT slotA;
    rc5WordT slotB;
    rc5WordT encA;
    rc5WordT encB;
    rc5WordT decA;
    rc5WordT decB;

    // Stall only when full and blocked downstream
    assign upstream.ready = !slotValid || downstream.ready;

    ////////////////////////////////////////////////////////////
    // Round datapath, both directions
    ////////////////////////////////////////////////////////////
    always_comb begin
        // A = ((A ^ B) <<< B) + S[2r]
        encA = rotLeft(upstream.wordA ^ upstream.wordB, upstream.wordB[RotBits-1:0])
             + i_keyTable[2*EncRound];
        // B = ((B ^ A) <<< A) + S[2r+1], new A
        encB = rotLeft(upstream.wordB ^ encA, encA[RotBits-1:0])
             + i_keyTable[2*EncRound+1];
        // B undone first
        decB = rotRight(upstream.wordB - i_keyTable[2*DecRound+1], upstream.wordA[RotBits-1:0])
             ^ upstream.wordA;
        // then A, using the recovered B
        decA = rotRight(upstream.wordA - i_keyTable[2*DecRound], decB[RotBits-1:0])
             ^ decB;
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            slotValid <= 1'b0;
        end else if (upstream.ready) begin
            slotValid <= upstream.valid;
        end
    end

    // Opcode rides along with the words
    always_ff @(posedge clk) begin
        if (upstream.valid && upstream.ready) begin
            slotOp <= upstream.op;
            if (upstream.op == OpEncrypt) begin
                slotA <= encA;
                slotB <= encB;
            end else begin
                slotA <= decA;
                slotB <= decB;
            end
        end
    end

    assign downstream.valid = slotValid;
    assign downstream.op    = slotOp;
    assign downstream.wordA = slotA;
    assign downstream.wordB = slotB;

endmodule

// File: rc5Core.sv
`timescale 1ns/1ps

module rc5Core (
    input  logic                                                     clk,
    input  logic                                                     clr,
    // Key load
    input  logic                                                     i_keyValid,
    input  logic [rc5ParamPkg::KeyWords*rc5ParamPkg::WordWidth-1:0] i_key,
    output logic                                                     o_keyReady,
    // Blocks in
    input  logic                                                     i_valid,
    output logic                                                     o_ready,
    input  rc5PipePkg::rc5OpT                                        i_op,
    input  logic [2*rc5ParamPkg::WordWidth-1:0]                      i_data,
    // Blocks out
    output logic                                                     o_valid,
    input  logic                                                     i_ready,
    output rc5PipePkg::rc5OpT                                        o_op,
    output logic [2*rc5ParamPkg::WordWidth-1:0]                      o_data
);
    import rc5ParamPkg::*;

    // Entry whitening, rounds, exit whitening
    localparam int NumStages = NumRounds + 2;

    keyTableT               keyTable;
    logic                   tableValid;
    logic                   pipeEmpty;
    logic [NumStages-1:0]   stageValid;

    // link[n] feeds stage n, link[NumStages] is the output
    rc5StageIf link [NumStages+1] ();

    rc5KeyExpand keyExpand (
        .clk          (clk),
        .clr          (clr),
        .i_keyValid   (i_keyValid),
        .i_key        (i_key),
        .i_pipeEmpty  (pipeEmpty),
        .o_keyReady   (o_keyReady),
        .o_tableValid (tableValid),
        .o_keyTable   (keyTable)
    );

    ////////////////////////////////////////////////////////////
    // Input and output ends
    ////////////////////////////////////////////////////////////
    // Blocks held off until a table exists
    assign link[0].valid = i_valid && tableValid;
    assign link[0].op    = i_op;
    assign link[0].wordA = i_data[2*WordWidth-1:WordWidth];
    assign link[0].wordB = i_data[WordWidth-1:0];
    assign o_ready       = link[0].ready && tableValid;

    assign o_valid              = link[NumStages].valid;
    assign o_op                 = link[NumStages].op;
    assign o_data               = {link[NumStages].wordA, link[NumStages].wordB};
    assign link[NumStages].ready = i_ready;

    // Nothing in flight when every slot is empty
    for (genvar s = 0; s < NumStages; s++) begin : gValid
        assign stageValid[s] = link[s+1].valid;
    end
    assign pipeEmpty = ~|stageValid;

    ////////////////////////////////////////////////////////////
    // Stage chain
    ////////////////////////////////////////////////////////////
    rc5WhitenStage #(.AtOutput(1'b0)) entryWhiten (
        .clk (clk), .clr (clr), .i_keyTable (keyTable),
        .upstream (link[0]), .downstream (link[1])
    );

    for (genvar r = 1; r <= NumRounds; r++) begin : gRound
        rc5RoundStage #(.RoundIdx(r)) roundStage (
            .clk (clk), .clr (clr), .i_keyTable (keyTable),
            .upstream (link[r]), .downstream (link[r+1])
        );
    end

    rc5WhitenStage #(.AtOutput(1'b1)) exitWhiten (
        .clk (clk), .clr (clr), .i_keyTable (keyTable),
        .upstream (link[NumStages-1]), .downstream (link[NumStages])
    );

endmodule

// File: tbRc5Core.sv
`timescale 1ns/1ps

module tbRc5Core;
    import rc5ParamPkg::*;
    import rc5PipePkg::*;

    // Block counts per phase in order enc, dec, mixed, back-pressure, after reload
    localparam int NumBlocks  = 200 + 200 + 200 + 200 + 100;
    localparam int KeyLoads   = 2;
    localparam int CycleLimit = (NumBlocks + 14) * 4 + 200 * KeyLoads;

    logic                     clk;
    logic                     clr;
    logic                     i_keyValid;
    logic [4*WordWidth-1:0]   i_key;
    logic                     o_keyReady;
    logic                     i_valid;
    logic                     o_ready;
    rc5OpT                    i_op;
    logic [2*WordWidth-1:0]   i_data;
    logic                     o_valid;
    logic                     i_ready;
    rc5OpT                    o_op;
    logic [2*WordWidth-1:0]   o_data;

    keyTableT                 modelTable;
    rc5OpT                    wantOp [$];
    logic [63:0]              wantData [$];
    logic [63:0]              plainSent [$];
    logic [63:0]              cipherSeen [$];
    logic                     captureCt;
    logic                     randomReady;
    int                       cycleCount;
    logic [63:0]              blockData;
    rc5OpT                    blockOp;

    rc5Core dut0 (
        .clk (clk), .clr (clr),
        .i_keyValid (i_keyValid), .i_key (i_key), .o_keyReady (o_keyReady),
        .i_valid (i_valid), .o_ready (o_ready), .i_op (i_op), .i_data (i_data),
        .o_valid (o_valid), .i_ready (i_ready), .o_op (o_op), .o_data (o_data)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic reportError(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic rc5WordT rotl32(input rc5WordT v, input logic [4:0] n);
        logic [63:0] dbl;
        // Upper half of the doubled word after the shift
        dbl = {v, v} << n;
        return dbl[63:32];
    endfunction

    function automatic rc5WordT rotr32(input rc5WordT v, input logic [4:0] n);
        logic [63:0] dbl;
        dbl = {v, v} >> n;
        return dbl[31:0];
    endfunction

    function automatic keyTableT expandKey(input logic [127:0] key);
        keyTableT s;
        rc5WordT  l [KeyWords];
        rc5WordT  a;
        rc5WordT  b;
        int       i;
        int       j;
        for (int n = 0; n < TableWords; n++) begin
            s[n] = MagicP + rc5WordT'(n) * MagicQ;
        end
        // Key word 0 is the low 32 bits
        for (int k = 0; k < KeyWords; k++) begin
            l[k] = key[32*k +: 32];
        end
        a = '0;
        b = '0;
        i = 0;
        j = 0;
        // Three passes over the table
        for (int step = 0; step < MixSteps; step++) begin
            a    = rotl32(s[i] + a + b, 5'd3);
            s[i] = a;
            b    = rotl32(l[j] + a + b, 5'(a + b));
            l[j] = b;
            i    = (i + 1) % TableWords;
            j    = (j + 1) % KeyWords;
        end
        return s;
    endfunction

    function automatic logic [63:0] encryptBlock(input logic [63:0] pt, input keyTableT s);
        rc5WordT a;
        rc5WordT b;
        a = pt[63:32] + s[0];
        b = pt[31:0] + s[1];
        for (int r = 1; r <= NumRounds; r++) begin
            a = rotl32(a ^ b, b[4:0]) + s[2*r];
            b = rotl32(b ^ a, a[4:0]) + s[2*r+1];
        end
        return {a, b};
    endfunction

    function automatic logic [63:0] decryptBlock(input logic [63:0] ct, input keyTableT s);
        rc5WordT a;
        rc5WordT b;
        a = ct[63:32];
        b = ct[31:0];
        // Rounds in reverse, B before A
        for (int r = NumRounds; r >= 1; r--) begin
            b = rotr32(b - s[2*r+1], a[4:0]) ^ a;
            a = rotr32(a - s[2*r], b[4:0]) ^ b;
        end
        return {a - s[0], b - s[1]};
    endfunction

    function automatic logic [63:0] modelBlock(input rc5OpT op, input logic [63:0] data);
        return (op == OpEncrypt) ? encryptBlock(data, modelTable)
                                 : decryptBlock(data, modelTable);
    endfunction

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////
    // Step to 1 ns past the next rising edge and pick i_ready there
    task automatic nextCycle();
        @(posedge clk);
        #1;
        if (randomReady) begin
            i_ready = ($urandom_range(99) < 60);
        end else begin
            i_ready = 1'b1;
        end
    endtask

    task automatic sendBlock(input rc5OpT op, input logic [63:0] data, input logic [63:0] want);
        logic taken;
        taken   = 1'b0;
        i_valid = 1'b1;
        i_op    = op;
        i_data  = data;
        // Inputs settled by the falling edge and transfer on the next rise
        while (!taken) begin
            @(negedge clk);
            taken = o_ready;
            nextCycle();
        end
        i_valid = 1'b0;
        wantOp.push_back(op);
        wantData.push_back(want);
    endtask

    task automatic loadKey(input logic [127:0] key);
        int lowCycles;
        i_keyValid = 1'b1;
        i_key      = key;
        @(negedge clk);
        while (!o_keyReady) begin
            nextCycle();
            @(negedge clk);
        end
        nextCycle();
        i_keyValid = 1'b0;
        modelTable = expandKey(key);
        lowCycles  = 0;
        @(negedge clk);
        // Busy while mixing with no blocks accepted
        while (!o_keyReady) begin
            assert (!o_ready) else reportError("o_ready went high while the key was mixing");
            lowCycles++;
            nextCycle();
            @(negedge clk);
        end
        assert (lowCycles == MixSteps + 1)
            else reportError($sformatf("o_keyReady came back after %0d cycles, expected %0d",
                                       lowCycles, MixSteps + 1));
        assert (o_ready) else reportError("o_ready stayed low after the key expansion finished");
        nextCycle();
    endtask

    task automatic drainPipe();
        while (wantOp.size() != 0) begin
            nextCycle();
        end
    endtask

    // Output side sampled at the falling edge where everything is stable
    always @(negedge clk) begin
        if (!clr && o_valid && i_ready) begin
            assert (wantOp.size() != 0) else reportError("output block appeared with none expected");
            assert (o_op == wantOp[0])
                else reportError($sformatf("MISMATCH o_op got %h expected %h", o_op, wantOp[0]));
            assert (o_data == wantData[0])
                else reportError($sformatf("MISMATCH o_data got %h expected %h",
                                           o_data, wantData[0]));
            if (captureCt) begin
                cipherSeen.push_back(o_data);
            end
            void'(wantOp.pop_front());
            void'(wantData.pop_front());
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            reportError($sformatf("Timeout after %0d cycles with %0d blocks still expected",
                                  cycleCount, wantOp.size()));
        end
    end

    initial begin
        clk         = 1'b0;
        clr         = 1'b1;
        i_keyValid  = 1'b0;
        i_key       = '0;
        i_valid     = 1'b0;
        i_op        = OpEncrypt;
        i_data      = '0;
        i_ready     = 1'b1;
        captureCt   = 1'b0;
        randomReady = 1'b0;
        cycleCount  = 0;
        void'($urandom(32'hbdb1a39f));

        repeat (16) @(posedge clk);
        #1;
        clr = 1'b0;

        // Reset state with nothing accepted before a key
        @(negedge clk);
        assert (!o_valid) else reportError("o_valid high after reset");
        assert (!o_ready) else reportError("o_ready high before any key was loaded");
        assert (o_keyReady) else reportError("o_keyReady low after reset");
        nextCycle();
        loadKey({$urandom, $urandom, $urandom, $urandom});

        // Encryption with ciphertexts kept for the round trip
        captureCt = 1'b1;
        for (int k = 0; k < 200; k++) begin
            blockData = {$urandom, $urandom};
            plainSent.push_back(blockData);
            sendBlock(OpEncrypt, blockData, encryptBlock(blockData, modelTable));
        end
        drainPipe();
        captureCt = 1'b0;

        // Decryption
        for (int k = 0; k < 200; k++) begin
            blockData = {$urandom, $urandom};
            sendBlock(OpDecrypt, blockData, decryptBlock(blockData, modelTable));
        end

        // Mixed ops where earlier ciphertexts must give back the plaintext
        for (int k = 0; k < 200; k++) begin
            if ($urandom_range(1) == 1) begin
                blockOp   = $urandom_range(1) ? OpDecrypt : OpEncrypt;
                blockData = {$urandom, $urandom};
                sendBlock(blockOp, blockData, modelBlock(blockOp, blockData));
            end else begin
                sendBlock(OpDecrypt, cipherSeen[k], plainSent[k]);
            end
        end

        // Back-pressure and gaps on the input
        randomReady = 1'b1;
        for (int k = 0; k < 200; k++) begin
            while ($urandom_range(99) < 40) begin
                nextCycle();
            end
            blockOp   = $urandom_range(1) ? OpDecrypt : OpEncrypt;
            blockData = {$urandom, $urandom};
            sendBlock(blockOp, blockData, modelBlock(blockOp, blockData));
        end
        drainPipe();
        randomReady = 1'b0;
        nextCycle();

        // Second key once the pipeline is empty
        loadKey({$urandom, $urandom, $urandom, $urandom});
        for (int k = 0; k < 100; k++) begin
            blockOp   = $urandom_range(1) ? OpDecrypt : OpEncrypt;
            blockData = {$urandom, $urandom};
            sendBlock(blockOp, blockData, modelBlock(blockOp, blockData));
        end
        drainPipe();
        repeat (4) nextCycle();

        // Drained pipeline leaves nothing valid and takes a key again
        assert (!o_valid) else reportError("o_valid still high after every expected block came out");
        assert (o_keyReady) else reportError("o_keyReady low with the pipeline drained");
        $display("All tests passed");
        $finish;
    end

endmodule

// File: sim.f
rc5ParamPkg.sv
rc5PipePkg.sv
rc5StageIf.sv
rc5KeyExpand.sv
rc5WhitenStage.sv
rc5RoundStage.sv
rc5Core.sv
tbRc5Core.sv
